//--- vlog.f
+incdir+include
source/cpu_pkg.sv
source/fetch_unit.sv
source/register_file.sv
source/decode_unit.sv
source/execute_unit.sv
source/memory_stage.sv
source/cpu_top.sv
dv/cpu_assert.sv
dv/cpu_tb.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = cpu_tb
FILELIST = vlog.f
OBJDIR   = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: compile
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1 || echo "STATUS: FAIL" >> $(LOG)
	@cat $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- dv/cpu_tb.sv
// ==================================================
// programs run from a 256-word instruction model
// data model uses address bits 7..0, done after 1 to 4 cycles
// every program must end in a branch to itself
// ==================================================
`include "cpu_consts.svh"

module cpu_tb;
    timeunit 1ns;
    timeprecision 1ps;

    logic           Clock;
    logic           Reset;
    cpu_pkg::word_t instr_in;
    cpu_pkg::word_t data_in = '0;
    logic           data_done = 1'b0;
    cpu_pkg::word_t instr_addr;
    cpu_pkg::word_t data_addr;
    cpu_pkg::word_t data_out;
    logic           read_data;
    logic           write_data;

    cpu_pkg::word_t imem [256];
    cpu_pkg::word_t dmem [256];
    cpu_pkg::word_t ref_mem [256];
    cpu_pkg::word_t exp_addr [$];
    cpu_pkg::word_t exp_data [$];
    cpu_pkg::word_t obs_addr [$];
    cpu_pkg::word_t obs_data [$];
    cpu_pkg::word_t halt_pc;
    int seed = 18;
    int n_ins;
    int cycles;
    int limit = 1000;
    int store_count;
    int wait_left;
    logic waiting;

    cpu_top cpu_top_i (
        .Clock(Clock), .Reset(Reset),
        .instr_in(instr_in), .data_in(data_in), .data_done(data_done),
        .instr_addr(instr_addr), .data_addr(data_addr), .data_out(data_out),
        .read_data(read_data), .write_data(write_data)
    );

    assign instr_in = imem[instr_addr[7:0]];   // combinational instruction port

    initial begin
        Clock = 1'b0;
        forever #4 Clock = ~Clock;
    end

    task automatic check_word(string name, cpu_pkg::word_t got, cpu_pkg::word_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s got %h expected %h", name, got, exp);
            $display("STATUS: FAIL");
            $fatal(1);
        end
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s got %h expected %h", name, got, exp);
            $display("STATUS: FAIL");
            $fatal(1);
        end
    endtask

    function automatic cpu_pkg::word_t fill_word(logic [7:0] a);
        return {a ^ 8'ha5, ~a};
    endfunction

    function automatic cpu_pkg::word_t enc_i(logic [2:0] opc, int rx, int imm);
        return {opc, 1'b1, rx[2:0], imm[8:0]};
    endfunction

    function automatic cpu_pkg::word_t enc_r(logic [2:0] opc, int rx, int ry);
        return {opc, 1'b0, rx[2:0], 6'b0, ry[2:0]};
    endfunction

    function automatic cpu_pkg::word_t enc_br(int cond, int off);
        return {`CPU_OPC_MVT_B, 1'b0, cond[2:0], off[8:0]};
    endfunction

    task automatic emit(cpu_pkg::word_t w);
        imem[n_ins] = w;
        n_ins++;
    endtask

    // ISA model, returns executed instruction count or -1 without halt
    function automatic int ref_run();
        cpu_pkg::word_t regs [8];
        cpu_pkg::word_t pc;
        cpu_pkg::word_t next_pc;
        cpu_pkg::word_t w;
        cpu_pkg::word_t op2;
        cpu_pkg::word_t sext;
        logic [16:0]    diff;
        logic [2:0]     opc;
        logic [2:0]     rx;
        logic           fn;
        logic           fz;
        logic           fc;
        logic           take;
        int             steps;
        for (int i = 0; i < 8; i++) regs[i] = '0;
        for (int a = 0; a < 256; a++) ref_mem[a] = fill_word(a[7:0]);
        exp_addr.delete();
        exp_data.delete();
        fn = 1'b0;
        fz = 1'b0;
        fc = 1'b0;
        pc = '0;
        steps = 0;
        while (steps < 4000) begin
            w       = imem[pc[7:0]];
            opc     = w[15:13];
            rx      = w[11:9];
            sext    = {{7{w[8]}}, w[8:0]};
            op2     = w[12] ? sext : regs[w[2:0]];
            next_pc = pc + 16'd1;
            steps++;
            if (w != '0) begin
                case (opc)
                    3'd0: regs[rx] = op2;
                    3'd1: begin
                        if (w[12]) begin
                            regs[rx] = {w[7:0], 8'h00};
                        end else begin
                            case (rx)
                                3'd1: take = fz;
                                3'd2: take = !fz;
                                3'd3: take = !fc;
                                3'd4: take = fc;
                                3'd5: take = !fz && !fn;
                                3'd6: take = !fz && fn;
                                default: take = 1'b1;
                            endcase
                            if (take && (pc + 16'd1 + sext) == pc) begin
                                halt_pc = pc;
                                return steps;
                            end
                            if (take) next_pc = pc + 16'd1 + sext;
                        end
                    end
                    3'd2: regs[rx] = regs[rx] + op2;
                    3'd3: regs[rx] = regs[rx] - op2;
                    3'd4: regs[rx] = ref_mem[op2[7:0]];
                    3'd5: begin
                        exp_addr.push_back(op2);
                        exp_data.push_back(regs[rx]);
                        ref_mem[op2[7:0]] = regs[rx];
                    end
                    3'd7: begin
                        if (w[12] || w[8:3] == 6'd0) begin   // cmp forms only
                            diff = {1'b0, regs[rx]} - {1'b0, op2};
                            fn   = diff[15];
                            fz   = diff[15:0] == 16'd0;
                            fc   = diff[16];
                        end
                    end
                    default: ;
                endcase
            end
            pc = next_pc;
        end
        return -1;
    endfunction

    // data memory, done is held for one cycle
    always @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            data_done <= 1'b0;
            data_in   <= '0;
            waiting   = 1'b0;
        end else if (data_done) begin
            data_done <= 1'b0;
        end else if (read_data || write_data) begin
            if (!waiting) begin
                wait_left = $random(seed) & 3;
                waiting   = 1'b1;
            end
            if (wait_left == 0) begin
                data_done <= 1'b1;
                data_in   <= dmem[data_addr[7:0]];
                waiting   = 1'b0;
                if (write_data) begin
                    dmem[data_addr[7:0]] = data_out;
                    obs_addr.push_back(data_addr);
                    obs_data.push_back(data_out);
                end
            end else begin
                wait_left--;
            end
        end
    end

    // store compare against the reference order
    always @(posedge Clock) begin
        while (obs_addr.size() > 0) begin
            if (exp_addr.size() == 0) begin
                $display("a store appeared that the reference program never makes");
                $display("STATUS: FAIL");
                $fatal(1);
            end
            check_word("data_addr", obs_addr.pop_front(), exp_addr.pop_front());
            check_word("data_out", obs_data.pop_front(), exp_data.pop_front());
            store_count++;
        end
    end

    always @(posedge Clock) begin
        cycles = cycles + 1;
        if (cycles > limit) begin
            $display("timeout after %0d cycles without reaching the halt loop", cycles);
            $display("STATUS: FAIL");
            $fatal(1);
        end
    end

    task automatic clear_program();
        for (int a = 0; a < 256; a++) imem[a] = '0;
        n_ins = 0;
    endtask

    task automatic build_arith();
        clear_program();
        emit(enc_i(`CPU_OPC_MV, 0, 5));
        emit(enc_i(`CPU_OPC_MVT_B, 1, 'h12));   // r1 = 0x1200
        emit(enc_i(`CPU_OPC_ADD, 1, 3));
        emit(enc_i(`CPU_OPC_SUB, 0, -7));
        emit(enc_r(`CPU_OPC_ADD, 0, 1));
        emit(enc_r(`CPU_OPC_MV, 2, 0));
        emit(enc_r(`CPU_OPC_SUB, 2, 1));
        emit(enc_i(`CPU_OPC_ST, 0, 'h10));
        emit(enc_i(`CPU_OPC_ST, 2, 'h11));
        emit(enc_i(`CPU_OPC_MV, 3, 'h20));
        emit(enc_r(`CPU_OPC_ST, 1, 3));
        emit(enc_i(`CPU_OPC_LD, 4, 'h10));      // load then immediate use
        emit(enc_i(`CPU_OPC_ADD, 4, 1));
        emit(enc_i(`CPU_OPC_ST, 4, 'h12));
        emit(enc_r(`CPU_OPC_LD, 5, 3));
        emit(enc_r(`CPU_OPC_SUB, 5, 4));
        emit(enc_r(`CPU_OPC_ST, 5, 3));
        emit(enc_i(`CPU_OPC_LD, 0, 'h05));      // preset fill word
        emit(enc_r(`CPU_OPC_ADD, 0, 0));
        emit(enc_i(`CPU_OPC_ST, 0, 'h13));
        emit(enc_i(`CPU_OPC_SUB, 1, -256));
        emit(enc_i(`CPU_OPC_ST, 1, 'h14));
        emit(enc_br(0, -1));
    endtask

    task automatic build_branch();
        int loop_pc;
        clear_program();
        emit(enc_i(`CPU_OPC_MV, 0, 5));
        emit(enc_i(`CPU_OPC_MV, 1, 5));
        emit(enc_r(`CPU_OPC_OTHER, 0, 1));      // equal, no borrow
        emit(enc_br(1, 1));
        emit(enc_i(`CPU_OPC_ST, 0, 'h20));
        emit(enc_br(2, 1));
        emit(enc_i(`CPU_OPC_ST, 1, 'h21));
        emit(enc_i(`CPU_OPC_OTHER, 0, 7));      // negative with borrow
        emit(enc_br(3, 1));
        emit(enc_i(`CPU_OPC_ST, 0, 'h22));
        emit(enc_br(4, 1));
        emit(enc_i(`CPU_OPC_ST, 0, 'h23));
        emit(enc_br(5, 1));
        emit(enc_i(`CPU_OPC_ST, 1, 'h24));
        emit(enc_br(6, 1));
        emit(enc_i(`CPU_OPC_ST, 1, 'h25));
        emit(enc_i(`CPU_OPC_OTHER, 1, 2));      // positive, no borrow
        emit(enc_br(5, 1));
        emit(enc_i(`CPU_OPC_ST, 0, 'h26));
        emit(enc_br(3, 1));
        emit(enc_i(`CPU_OPC_ST, 0, 'h27));
        emit(enc_br(1, 1));
        emit(enc_i(`CPU_OPC_ST, 0, 'h28));
        emit(enc_i(`CPU_OPC_MV, 2, 3));
        emit(enc_i(`CPU_OPC_MV, 3, 0));
        loop_pc = n_ins;
        emit(enc_i(`CPU_OPC_ADD, 3, 2));
        emit(enc_i(`CPU_OPC_SUB, 2, 1));
        emit(enc_i(`CPU_OPC_ST, 3, 'h30));
        emit(enc_i(`CPU_OPC_OTHER, 2, 0));
        emit(enc_br(2, loop_pc - (n_ins + 1)));
        emit(enc_i(`CPU_OPC_ST, 3, 'h31));
        emit(enc_br(0, -1));
    endtask

    task automatic build_random();
        logic [31:0] val;
        logic [2:0]  rx;
        logic [2:0]  ry;
        clear_program();
        emit(enc_i(`CPU_OPC_MV, 6, 'h40));      // r6 is the base, never rewritten
        for (int k = 0; k < 40; k++) begin
            val = $random(seed);
            rx  = val[10:8] % 3'd6;
            ry  = val[13:11] % 3'd7;
            case (val[2:0])
                3'd0: emit(enc_i(`CPU_OPC_MV, int'(rx), int'(val[24:16])));
                3'd1: emit(enc_i(`CPU_OPC_MVT_B, int'(rx), int'(val[23:16])));
                3'd2: emit(enc_i(`CPU_OPC_ADD, int'(rx), int'(val[24:16])));
                3'd3: emit(enc_r(`CPU_OPC_SUB, int'(rx), int'(ry)));
                3'd4: emit(enc_r(`CPU_OPC_ADD, int'(rx), int'(ry)));
                3'd5: emit(enc_i(`CPU_OPC_LD, int'(rx), int'(val[21:16])));
                3'd6: emit(enc_i(`CPU_OPC_ST, int'(rx), int'(val[21:16])));
                default: emit(enc_r(val[3] ? `CPU_OPC_LD : `CPU_OPC_ST, int'(rx), 6));
            endcase
        end
        emit(enc_br(0, -1));
    endtask

    task automatic run_program();
        int steps;
        int n_exp;
        int first_mem;
        steps = ref_run();
        if (steps < 0) begin
            $display("reference model found no halt loop in the program");
            $display("STATUS: FAIL");
            $fatal(1);
        end
        n_exp = exp_addr.size();
        first_mem = 0;
        while (first_mem < n_ins &&
               imem[first_mem][15:13] != `CPU_OPC_LD &&
               imem[first_mem][15:13] != `CPU_OPC_ST) begin
            first_mem++;
        end
        for (int a = 0; a < 256; a++) dmem[a] = fill_word(a[7:0]);
        obs_addr.delete();
        obs_data.delete();
        store_count = 0;
        cycles      = 0;
        limit       = 40 * steps + 5;
        repeat (5) @(posedge Clock);
        Reset <= 1'b0;
        @(negedge Clock);
        check_word("instr_addr", instr_addr, 16'h0000);
        // bus stays idle until the first load or store is fetched
        while (instr_addr != cpu_pkg::word_t'(first_mem)) begin
            check_bit("read_data", read_data, 1'b0);
            check_bit("write_data", write_data, 1'b0);
            @(negedge Clock);
        end
        while (!(store_count == n_exp && instr_addr == halt_pc)) @(negedge Clock);
        repeat (4) @(negedge Clock);
        for (int a = 0; a < 256; a++) begin
            check_word("dmem", dmem[a], ref_mem[a]);
        end
        @(posedge Clock);
        Reset <= 1'b1;
    endtask

    initial begin
        Reset = 1'b1;
        clear_program();
        @(posedge Clock);
        build_arith();
        run_program();
        build_branch();
        run_program();
        build_random();
        run_program();
        $display("STATUS: PASS");
        $finish;
    end

endmodule

//--- dv/cpu_assert.sv
// ==================================================
// data bus checks, bound into cpu_top
// a request must not change until data_done is seen
// ==================================================
module cpu_assert (
    input logic           Clock,
    input logic           Reset,
    input logic           read_data,
    input logic           write_data,
    input logic           data_done,
    input cpu_pkg::word_t data_addr,
    input cpu_pkg::word_t data_out
);
    timeunit 1ns;
    timeprecision 1ps;

    // a load and a store never share the bus
    assert property (@(posedge Clock) disable iff (Reset)
        !(read_data && write_data))
    else $error("read_data and write_data high together");

    // waiting request keeps address, data and direction
    assert property (@(posedge Clock) disable iff (Reset)
        ((read_data || write_data) && !data_done) |=>
        ($stable(data_addr) && $stable(data_out) &&
         $stable(read_data) && $stable(write_data)))
    else $error("data bus request changed before data_done");

endmodule

bind cpu_top cpu_assert cpu_assert_i (
    .Clock(Clock), .Reset(Reset),
    .read_data(read_data), .write_data(write_data), .data_done(data_done),
    .data_addr(data_addr), .data_out(data_out)
);

//--- source/cpu_top.sv
// ==================================================
// five-stage in-order CPU, fetch to writeback
// mem_stall freezes everything above memory
// dec_stall freezes fetch and sends a bubble to execute
// ==================================================
`include "cpu_consts.svh"

module cpu_top (
    input  logic           Clock,
    input  logic           Reset,
    input  cpu_pkg::word_t instr_in,
    input  cpu_pkg::word_t data_in,
    input  logic           data_done,
    output cpu_pkg::word_t instr_addr,
    output cpu_pkg::word_t data_addr,
    output cpu_pkg::word_t data_out,
    output logic           read_data,
    output logic           write_data
);

    cpu_pkg::word_t      pc_value;
    logic                pc_advance;
    cpu_pkg::stage_rec_t fetch_rec;
    cpu_pkg::stage_rec_t dec_rec;
    cpu_pkg::stage_rec_t exe_rec;
    cpu_pkg::reg_idx_t   rd_a_idx;
    cpu_pkg::reg_idx_t   rd_b_idx;
    cpu_pkg::word_t      rd_a;
    cpu_pkg::word_t      rd_b;
    logic                mem_stall;
    logic                dec_stall;
    cpu_pkg::reg_mask_t  busy_regs;     // writers in execute, memory, writeback
    logic                wb_en;
    cpu_pkg::reg_idx_t   wb_idx;
    cpu_pkg::word_t      wb_data;

    fetch_unit fetch_unit_i (
        .Clock(Clock), .Reset(Reset),
        .instr_in(instr_in), .pc_value(pc_value),
        .mem_stall(mem_stall), .dec_stall(dec_stall),
        .instr_addr(instr_addr), .pc_advance(pc_advance), .fetch_rec(fetch_rec)
    );

    register_file register_file_i (
        .Clock(Clock), .Reset(Reset),
        .rd_a_idx(rd_a_idx), .rd_b_idx(rd_b_idx),
        .wb_en(wb_en), .wb_idx(wb_idx), .wb_data(wb_data), .pc_advance(pc_advance),
        .rd_a(rd_a), .rd_b(rd_b), .pc_value(pc_value)
    );

    decode_unit decode_unit_i (
        .Clock(Clock), .Reset(Reset),
        .fetch_rec(fetch_rec), .rd_a(rd_a), .rd_b(rd_b),
        .busy_regs(busy_regs), .mem_stall(mem_stall),
        .rd_a_idx(rd_a_idx), .rd_b_idx(rd_b_idx),
        .dec_stall(dec_stall), .dec_rec(dec_rec)
    );

    execute_unit execute_unit_i (
        .Clock(Clock), .Reset(Reset),
        .dec_rec(dec_rec), .mem_stall(mem_stall), .exe_rec(exe_rec)
    );

    memory_stage memory_stage_i (
        .Clock(Clock), .Reset(Reset),
        .exe_rec(exe_rec), .data_in(data_in), .data_done(data_done),
        .data_addr(data_addr), .data_out(data_out),
        .read_data(read_data), .write_data(write_data),
        .mem_stall(mem_stall), .busy_regs(busy_regs),
        .wb_en(wb_en), .wb_idx(wb_idx), .wb_data(wb_data)
    );

endmodule

//--- source/memory_stage.sv
// ==================================================
// data bus request is held until data_done at a clock edge
// memory latch drives the register write port
// writeback latch only tracks pending writers
// ==================================================
`include "cpu_consts.svh"

module memory_stage (
    input  logic                Clock,
    input  logic                Reset,
    input  cpu_pkg::stage_rec_t exe_rec,
    input  cpu_pkg::word_t      data_in,
    input  logic                data_done,
    output cpu_pkg::word_t      data_addr,
    output cpu_pkg::word_t      data_out,
    output logic                read_data,
    output logic                write_data,
    output logic                mem_stall,
    output cpu_pkg::reg_mask_t  busy_regs,
    output logic                wb_en,
    output cpu_pkg::reg_idx_t   wb_idx,
    output cpu_pkg::word_t      wb_data
);

    logic                req;
    cpu_pkg::stage_rec_t mem_next;
    cpu_pkg::stage_rec_t mem_q;
    cpu_pkg::stage_rec_t wb_q;

    assign req        = exe_rec.valid && (exe_rec.read || exe_rec.write);
    assign read_data  = req && exe_rec.read;
    assign write_data = req && exe_rec.write;
    assign data_addr  = exe_rec.op2;        // steady while the execute latch holds
    assign data_out   = exe_rec.op1;
    assign mem_stall  = req && !data_done;

    always_comb begin
        mem_next = exe_rec;
        if (exe_rec.read) begin
            mem_next.result = data_in;
        end
        if (mem_stall) begin
            mem_next = '0;                   // bubble downstream while waiting
        end
    end

    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            mem_q <= '0;
            wb_q  <= '0;
        end else begin
            mem_q <= mem_next;
            wb_q  <= mem_q;
        end
    end

    assign wb_en     = mem_q.valid && mem_q.writeback;
    assign wb_idx    = mem_q.rx;
    assign wb_data   = mem_q.result;
    assign busy_regs = exe_rec.writes | mem_q.writes | wb_q.writes;

endmodule

//--- source/execute_unit.sv
// ==================================================
// ALU for mov, add and sub with a 17-bit carry path
// flags change only for cmp, failed conditions become nops
// ==================================================
`include "cpu_consts.svh"

module execute_unit (
    input  logic                Clock,
    input  logic                Reset,
    input  cpu_pkg::stage_rec_t dec_rec,
    input  logic                mem_stall,
    output cpu_pkg::stage_rec_t exe_rec
);

    logic [`CPU_WORD_W:0] alu_wide;    // top bit is the carry
    logic                 cond_ok;
    cpu_pkg::flags_t      flags_q;
    cpu_pkg::flags_t      flags_next;
    cpu_pkg::stage_rec_t  exe_next;
    cpu_pkg::stage_rec_t  exe_q;

    always_comb begin
        case (dec_rec.alu_op)
            cpu_pkg::mov_op: alu_wide = {1'b0, dec_rec.op2};
            cpu_pkg::add_op: alu_wide = {1'b0, dec_rec.op1} + {1'b0, dec_rec.op2};
            cpu_pkg::sub_op: alu_wide = {1'b0, dec_rec.op1} - {1'b0, dec_rec.op2};
            default:         alu_wide = '0;   // ld and st carry no result
        endcase
    end

    always_comb begin
        case (dec_rec.cond)
            cpu_pkg::eq: cond_ok = flags_q.zero;
            cpu_pkg::ne: cond_ok = !flags_q.zero;
            cpu_pkg::cc: cond_ok = !flags_q.carry;
            cpu_pkg::cs: cond_ok = flags_q.carry;
            cpu_pkg::pl: cond_ok = !flags_q.zero && !flags_q.negative;
            cpu_pkg::mi: cond_ok = !flags_q.zero && flags_q.negative;
            default:     cond_ok = 1'b1;
        endcase
    end

    assign flags_next.negative = alu_wide[`CPU_WORD_W-1];
    assign flags_next.zero     = alu_wide[`CPU_WORD_W-1:0] == '0;
    assign flags_next.carry    = alu_wide[`CPU_WORD_W];

    always_comb begin
        exe_next        = dec_rec;
        exe_next.result = alu_wide[`CPU_WORD_W-1:0];
        if (!cond_ok) begin
            exe_next = '0;                   // branch not taken
        end
    end

    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            exe_q   <= '0;
            flags_q <= '0;
        end else if (!mem_stall) begin
            exe_q <= exe_next;
            if (dec_rec.valid && dec_rec.set_flags) begin
                flags_q <= flags_next;
            end
        end
    end

    assign exe_rec = exe_q;

endmodule

//--- source/decode_unit.sv
// ==================================================
// decodes the fetch latch into a stage record
// stalls while any in-flight writer covers rx, ry or r7
// no forwarding, reads wait until the writer leaves writeback
// ==================================================
`include "cpu_consts.svh"

module decode_unit (
    input  logic                Clock,
    input  logic                Reset,
    input  cpu_pkg::stage_rec_t fetch_rec,
    input  cpu_pkg::word_t      rd_a,
    input  cpu_pkg::word_t      rd_b,
    input  cpu_pkg::reg_mask_t  busy_regs,
    input  logic                mem_stall,
    output cpu_pkg::reg_idx_t   rd_a_idx,
    output cpu_pkg::reg_idx_t   rd_b_idx,
    output logic                dec_stall,
    output cpu_pkg::stage_rec_t dec_rec
);

    cpu_pkg::word_t                     instr;
    logic [`CPU_OPC_MSB-`CPU_OPC_LSB:0] opcode;
    cpu_pkg::word_t                     imm_ext;
    logic                               cmp_form;
    cpu_pkg::reg_mask_t                 busy_all;
    logic                               raw_hit;
    cpu_pkg::stage_rec_t                dec_next;
    cpu_pkg::stage_rec_t                dec_q;

    assign instr    = fetch_rec.result;
    assign opcode   = instr[`CPU_OPC_MSB:`CPU_OPC_LSB];
    assign rd_a_idx = instr[`CPU_RX_MSB:`CPU_RX_LSB];
    assign rd_b_idx = instr[`CPU_REG_W-1:0];
    assign imm_ext  = {{(`CPU_WORD_W-`CPU_IMM_W){instr[`CPU_IMM_W-1]}},
                       instr[`CPU_IMM_W-1:0]};

    // opcode 7 is cmp when immediate or when bits 8..3 are zero
    assign cmp_form = instr[`CPU_IMM_BIT] || (instr[`CPU_IMM_W-1:`CPU_REG_W] == '0);

    always_comb begin
        dec_next           = '0;
        dec_next.valid     = fetch_rec.valid;
        dec_next.pc        = fetch_rec.pc;
        dec_next.rx        = rd_a_idx;
        dec_next.ry        = rd_b_idx;
        dec_next.imm       = instr[`CPU_IMM_BIT];
        dec_next.op1       = rd_a;
        dec_next.op2       = instr[`CPU_IMM_BIT] ? imm_ext : rd_b;
        dec_next.writeback = 1'b1;
        case (opcode)
            `CPU_OPC_MV: dec_next.alu_op = cpu_pkg::mov_op;
            `CPU_OPC_MVT_B: begin
                if (instr[`CPU_IMM_BIT]) begin
                    dec_next.alu_op = cpu_pkg::mov_op;
                    dec_next.op2    = instr << (`CPU_WORD_W / 2);  // low imm byte on top
                end else begin
                    // branch to pc + 1 + offset through r7
                    dec_next.imm    = 1'b1;
                    dec_next.alu_op = cpu_pkg::add_op;
                    dec_next.cond   = (&rd_a_idx) ? cpu_pkg::none
                                                  : cpu_pkg::cond_t'(rd_a_idx);
                    dec_next.rx     = `CPU_PC_REG;
                    dec_next.op1    = fetch_rec.pc + cpu_pkg::word_t'(1);
                    dec_next.op2    = imm_ext;
                end
            end
            `CPU_OPC_ADD: dec_next.alu_op = cpu_pkg::add_op;
            `CPU_OPC_SUB: dec_next.alu_op = cpu_pkg::sub_op;
            `CPU_OPC_LD:  dec_next.read   = 1'b1;        // address in op2
            `CPU_OPC_ST: begin
                dec_next.write     = 1'b1;               // data is rx in op1
                dec_next.writeback = 1'b0;
            end
            `CPU_OPC_OTHER: begin
                if (cmp_form) begin
                    dec_next.alu_op    = cpu_pkg::sub_op;
                    dec_next.set_flags = 1'b1;
                    dec_next.writeback = 1'b0;
                end else begin
                    dec_next.valid = 1'b0;
                end
            end
            default: dec_next.valid = 1'b0;             // logic ops not built
        endcase
        if (dec_next.valid && dec_next.writeback) begin
            dec_next.writes[dec_next.rx] = 1'b1;
        end
    end

    // own latch counts as in flight too
    assign busy_all  = busy_regs | dec_q.writes;
    assign raw_hit   = dec_next.valid &&
                       (busy_all[dec_next.rx] || (!dec_next.imm && busy_all[dec_next.ry]));
    assign dec_stall = raw_hit || busy_all[`CPU_PC_REG];

    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            dec_q <= '0;
        end else if (!mem_stall) begin
            dec_q <= dec_stall ? '0 : dec_next;  // bubble while stalled
        end
    end

    assign dec_rec = dec_q;

endmodule

//--- source/register_file.sv
// ==================================================
// eight registers, r7 is the program counter
// two combinational read ports, one write port
// a write to r7 wins over the fetch increment
// ==================================================
`include "cpu_consts.svh"

module register_file (
    input  logic              Clock,
    input  logic              Reset,
    input  cpu_pkg::reg_idx_t rd_a_idx,
    input  cpu_pkg::reg_idx_t rd_b_idx,
    input  logic              wb_en,
    input  cpu_pkg::reg_idx_t wb_idx,
    input  cpu_pkg::word_t    wb_data,
    input  logic              pc_advance,
    output cpu_pkg::word_t    rd_a,
    output cpu_pkg::word_t    rd_b,
    output cpu_pkg::word_t    pc_value
);

    cpu_pkg::word_t regs [`CPU_NUM_REGS];

    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            for (int i = 0; i < `CPU_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
            regs[`CPU_PC_REG] <= '1;          // first fetch lands on 0
        end else begin
            if (pc_advance) begin
                regs[`CPU_PC_REG] <= regs[`CPU_PC_REG] + cpu_pkg::word_t'(1);
            end
            if (wb_en) begin
                regs[wb_idx] <= wb_data;      // later assignment takes priority
            end
        end
    end

    assign rd_a     = regs[rd_a_idx];
    assign rd_b     = regs[rd_b_idx];
    assign pc_value = regs[`CPU_PC_REG];

endmodule

//--- source/fetch_unit.sv
// ==================================================
// instruction port is combinational, instr_in answers instr_addr
// r7 holds the address of the word in the fetch latch
// a latched word whose address no longer matches r7 is refetched
// ==================================================
`include "cpu_consts.svh"

module fetch_unit (
    input  logic                Clock,
    input  logic                Reset,
    input  cpu_pkg::word_t      instr_in,
    input  cpu_pkg::word_t      pc_value,
    input  logic                mem_stall,
    input  logic                dec_stall,
    output cpu_pkg::word_t      instr_addr,
    output logic                pc_advance,
    output cpu_pkg::stage_rec_t fetch_rec
);

    logic                stall;
    logic                stale;      // r7 rewritten behind the latched word
    cpu_pkg::stage_rec_t fetch_next;
    cpu_pkg::stage_rec_t fetch_q;

    assign stall      = mem_stall || dec_stall;
    assign stale      = fetch_q.pc != pc_value;
    assign pc_advance = !stall && !stale;
    assign instr_addr = pc_advance ? pc_value + cpu_pkg::word_t'(1) : pc_value;

    always_comb begin
        fetch_next        = '0;
        fetch_next.valid  = instr_in != '0;   // all-zero word is a nop
        fetch_next.pc     = instr_addr;
        fetch_next.result = instr_in;
    end

    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            fetch_q    <= '0;
            fetch_q.pc <= '1;                 // same as r7 after reset
        end else if (!stall) begin
            fetch_q <= fetch_next;
        end
    end

    // squash the wrong-path word left behind by a taken branch
    always_comb begin
        fetch_rec       = fetch_q;
        fetch_rec.valid = fetch_q.valid && !stale;
    end

endmodule

//--- source/cpu_pkg.sv
// ==================================================
// shared types for the five-stage pipeline
// a stage record with valid low is a nop in every stage
// ==================================================
`include "cpu_consts.svh"

package cpu_pkg;

    typedef logic [`CPU_WORD_W-1:0]   word_t;
    typedef logic [`CPU_REG_W-1:0]    reg_idx_t;
    typedef logic [`CPU_NUM_REGS-1:0] reg_mask_t;

    // status flags, written by cmp only
    typedef struct packed {
        logic negative;
        logic zero;
        logic carry;
    } flags_t;

    typedef enum logic [1:0] {
        nop_op,
        mov_op,
        add_op,
        sub_op
    } alu_op_t;

    // branch conditions as coded in the rx field
    typedef enum logic [2:0] {
        none = 3'd0,
        eq   = 3'd1,
        ne   = 3'd2,
        cc   = 3'd3,
        cs   = 3'd4,
        pl   = 3'd5,
        mi   = 3'd6
    } cond_t;

    typedef struct packed {
        logic      valid;
        word_t     pc;         // fetch address of the instruction
        word_t     op1;        // rx value, store data
        word_t     op2;        // second operand or memory address
        word_t     result;     // holds the raw word while in the fetch latch
        reg_idx_t  rx;
        reg_idx_t  ry;
        logic      imm;
        logic      writeback;
        logic      read;
        logic      write;
        logic      set_flags;
        alu_op_t   alu_op;
        cond_t     cond;
        reg_mask_t writes;     // registers this instruction will write
    } stage_rec_t;

endpackage

//--- include/cpu_consts.svh
// ==================================================
// fixed ISA constants for the 16-bit pipelined CPU
// word layout is III M XXX DDDDDDDDD or III M XXX 000000 YYY
// ==================================================
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

`define CPU_WORD_W   16
`define CPU_NUM_REGS 8
`define CPU_REG_W    3
`define CPU_PC_REG   3'd7   // r7 doubles as program counter

// instruction fields
`define CPU_OPC_MSB  15
`define CPU_OPC_LSB  13
`define CPU_IMM_BIT  12
`define CPU_RX_MSB   11
`define CPU_RX_LSB   9
`define CPU_IMM_W    9      // signed immediate in bits 8..0

// opcode 6 has no entry and decodes as a nop
`define CPU_OPC_MV    3'd0
`define CPU_OPC_MVT_B 3'd1  // mvt with imm bit set, branch without
`define CPU_OPC_ADD   3'd2
`define CPU_OPC_SUB   3'd3
`define CPU_OPC_LD    3'd4
`define CPU_OPC_ST    3'd5
`define CPU_OPC_OTHER 3'd7  // only the cmp forms are decoded

`endif
